// ==== verilog.f ====
design/dino_pkg.sv
design/uart_rx.sv
design/command_input.sv
design/player_motion.sv
design/obstacle_motion.sv
design/hit_score.sv
design/score_display.sv
design/dino_game_top.sv
verif/tb_clock.sv
verif/dino_game_tb.sv

// ==== Bender.yml ====
package:
  name: dino_game

sources:
  - design/dino_pkg.sv
  - design/uart_rx.sv
  - design/command_input.sv
  - design/player_motion.sv
  - design/obstacle_motion.sv
  - design/hit_score.sv
  - design/score_display.sv
  - design/dino_game_top.sv
  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/dino_game_tb.sv

// ==== verif/dino_game_tb.sv ====
`timescale 1ns/10ps

module dino_game_tb;

	localparam int CLK_HZ     = 25_000_000;
	localparam int BAUD       = 781_250;
	localparam int FRAME_DIV  = 64;
	localparam int DUCK_TICKS = 30;
	localparam int BIT_CLKS   = CLK_HZ / BAUD;   // 32 clocks per UART bit
	localparam int GROUND_Y   = 109;
	localparam int PEAK_Y     = GROUND_Y - 55;
	localparam int START_X    = 304;             // SCREEN_W - OBS_SIZE
	localparam int LAST_X     = START_X + 99;    // Largest respawn offset
	localparam int PLAYER_X   = 52;

	logic               Clock;
	logic               rst_n;
	logic               uart_rx;
	logic               key_jump_n;
	logic               key_duck_n;
	logic               restart_n;
	dino_pkg::seg_t     hex0;
	dino_pkg::seg_t     hex1;
	dino_pkg::seg_t     hex2;
	dino_pkg::seg_t     hex3;
	dino_pkg::seg_t     hex4;
	dino_pkg::seg_t     hex5;
	logic               crashed;
	dino_pkg::player_t  player;
	dino_pkg::x_coord_t obstacle_x;

	logic [31:0] lfsr_state;
	string       test_name;
	int          errors;
	int          errors_at_start;
	int          tests_passed;
	int          tests_failed;

	tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(10)) u_clock (.o_clock(Clock), .o_rst_n(rst_n));

	dino_game_top #(
		.CLK_HZ(CLK_HZ), .BAUD(BAUD), .FRAME_DIV(FRAME_DIV), .DUCK_TICKS(DUCK_TICKS)
	) DUT (
		.Clock(Clock), .rst_n(rst_n), .i_uart_rx(uart_rx),
		.i_key_jump_n(key_jump_n), .i_key_duck_n(key_duck_n), .i_restart_n(restart_n),
		.o_hex0(hex0), .o_hex1(hex1), .o_hex2(hex2),
		.o_hex3(hex3), .o_hex4(hex4), .o_hex5(hex5),
		.o_crashed(crashed), .o_player(player), .o_obstacle_x(obstacle_x)
	);

	// Active low, segment a in bit 0
	function automatic logic [6:0] seg_pattern(input int digit);
		case (digit)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			default: return 7'b0010000;
		endcase
	endfunction

	// Fibonacci LFSR, taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic take_random(input int nbits, output int value);
		value = 0;
		repeat (nbits) begin
			lfsr_state = lfsr_step(lfsr_state);
			value      = (value << 1) | lfsr_state[0];
		end
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("** Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_range(input string what, input int low, input int high, input int actual);
		assert (actual >= low && actual <= high) else begin
			$display("** Error: %s %s expected %0d..%0d actual %0d",
				test_name, what, low, high, actual);
			errors++;
		end
	endtask

	task automatic check_digit(input string what, input int digit, input logic [6:0] actual);
		assert (actual == seg_pattern(digit)) else begin
			$display("** Error: %s %s expected %b actual %b",
				test_name, what, seg_pattern(digit), actual);
			errors++;
		end
	endtask

	task automatic fail_check(input string msg);
		$display("%s: %s", test_name, msg);
		errors++;
	endtask

	task automatic check_display(input int score, input int high);
		check_digit("hex0", score % 10, hex0);
		check_digit("hex1", (score / 10) % 10, hex1);
		check_digit("hex2", (score / 100) % 10, hex2);
		check_digit("hex3", high % 10, hex3);
		check_digit("hex4", (high / 10) % 10, hex4);
		check_digit("hex5", (high / 100) % 10, hex5);
	endtask

	task automatic begin_test(input string name);
		test_name       = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("[%s] passed", test_name);
		end else begin
			tests_failed++;
			$display("[%s] FAILED with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic run_cycles(input int n);
		repeat (n) @(posedge Clock);
	endtask

	// Bits are {restart, duck, jump}, each held for a few cycles
	task automatic press_keys(input logic [2:0] pressed);
		@(posedge Clock);
		key_jump_n <= !pressed[0];
		key_duck_n <= !pressed[1];
		restart_n  <= !pressed[2];
		run_cycles(4);
		key_jump_n <= 1'b1;
		key_duck_n <= 1'b1;
		restart_n  <= 1'b1;
	endtask

	task automatic send_uart(input dino_pkg::byte_t data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};   // Stop, data LSB first, start
		for (int i = 0; i < 10; i++) begin
			@(posedge Clock);
			uart_rx <= frame[i];
			run_cycles(BIT_CLKS - 1);
		end
	endtask

	task automatic restart_game();
		press_keys(3'b100);
		run_cycles(4);
	endtask

	a_jump_peak: assert property (@(posedge Clock) disable iff (!rst_n)
		player.y >= PEAK_Y) else begin
		$display("** Error: %s player y expected >= %0d actual %0d", test_name, PEAK_Y, player.y);
		errors++;
	end

	a_duck_grounded: assert property (@(posedge Clock) disable iff (!rst_n)
		player.ducking |-> player.y == GROUND_Y) else begin
		$display("%s: player left the ground while ducking", test_name);
		errors++;
	end

	a_obstacle_span: assert property (@(posedge Clock) disable iff (!rst_n)
		obstacle_x > 4 && obstacle_x <= LAST_X) else begin
		$display("%s: obstacle x %0d outside the playfield", test_name, obstacle_x);
		errors++;
	end

	// Crash holds both motion blocks at their start positions
	a_crash_hold: assert property (@(posedge Clock) disable iff (!rst_n)
		$rose(crashed) |=> obstacle_x == START_X && player.y == GROUND_Y) else begin
		$display("%s: motion not held at start after the crash", test_name);
		errors++;
	end

	initial begin
		int count;
		int min_y;
		int last_x;
		int delay;
		int stray;
		int seen;

		uart_rx      = 1'b1;
		key_jump_n   = 1'b1;
		key_duck_n   = 1'b1;
		restart_n    = 1'b1;
		lfsr_state   = 32'h1641;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;

		begin_test("after_reset");
		count = 0;
		@(negedge Clock);
		while (!rst_n && count < 50) begin
			@(negedge Clock);
			count++;
		end
		if (!rst_n)
			fail_check("reset was never released");
		@(negedge Clock);
		check_display(0, 0);
		check_value("crashed", 0, crashed);
		check_value("player y", GROUND_Y, player.y);
		check_value("ducking", 0, player.ducking);
		check_value("obstacle x", START_X, obstacle_x);
		end_test();

		begin_test("uart_jump");
		restart_game();
		take_random(4, delay);
		run_cycles(delay);
		send_uart(dino_pkg::CMD_JUMP);
		count = 0;
		@(negedge Clock);
		while (player.y == GROUND_Y && count < 2 * FRAME_DIV) begin
			@(negedge Clock);
			count++;
		end
		if (player.y == GROUND_Y)
			fail_check("player never left the ground after J");
		min_y = GROUND_Y;
		count = 0;
		fork
			send_uart(dino_pkg::CMD_DUCK);   // No duck in the air
			while (player.y != GROUND_Y && count < 30 * FRAME_DIV) begin
				if (player.y < min_y)
					min_y = player.y;
				@(negedge Clock);
				count++;
			end
		join
		if (player.y != GROUND_Y)
			fail_check("player never landed");
		check_value("jump peak y", PEAK_Y, min_y);
		stray = dino_pkg::CMD_JUMP;
		count = 0;
		while ((stray == dino_pkg::CMD_JUMP || stray == dino_pkg::CMD_DUCK) && count < 16) begin
			take_random(8, stray);
			count++;
		end
		send_uart(dino_pkg::byte_t'(stray));
		min_y = GROUND_Y;
		seen  = 0;
		repeat (3 * FRAME_DIV) begin
			@(negedge Clock);
			if (player.y < min_y)
				min_y = player.y;
			seen |= player.ducking;
		end
		check_value("y after stray byte", GROUND_Y, min_y);
		check_value("ducking after stray byte", 0, seen);
		end_test();

		begin_test("duck_key");
		restart_game();
		press_keys(3'b010);
		count = 0;
		@(negedge Clock);
		while (!player.ducking && count < 20) begin
			@(negedge Clock);
			count++;
		end
		if (!player.ducking)
			fail_check("ducking never rose after the duck key");
		count = 0;
		min_y = GROUND_Y;
		fork
			send_uart(dino_pkg::CMD_JUMP);   // Must be ignored
			while (player.ducking && count < DUCK_TICKS * FRAME_DIV + 16) begin
				if (player.y < min_y)
					min_y = player.y;
				count++;
				@(negedge Clock);
			end
		join
		check_range("duck length in cycles", (DUCK_TICKS - 1) * FRAME_DIV + 1,
			DUCK_TICKS * FRAME_DIV, count);
		check_value("y while ducking", GROUND_Y, min_y);
		check_value("y after duck", GROUND_Y, player.y);
		end_test();

		begin_test("cleared_pass");
		restart_game();
		count = 0;
		@(negedge Clock);
		while (obstacle_x > 96 && count < 60 * FRAME_DIV) begin
			@(negedge Clock);
			count++;
		end
		if (obstacle_x > 96)
			fail_check("obstacle never reached x 96");
		press_keys(3'b001);
		seen  = 0;
		count = 0;
		@(negedge Clock);
		while (hex0 != seg_pattern(1) && count < 20 * FRAME_DIV) begin
			seen |= crashed;
			@(negedge Clock);
			count++;
		end
		if (hex0 != seg_pattern(1))
			fail_check("score never reached 1 after the jump");
		check_value("crashed during jump", 0, seen | crashed);
		count = 0;
		while (obstacle_x <= PLAYER_X && count < 8) begin
			@(negedge Clock);
			count++;
		end
		check_range("respawn x", START_X, LAST_X, obstacle_x);
		end_test();

		begin_test("crash");
		count  = 0;
		last_x = obstacle_x;
		@(negedge Clock);
		while (!crashed && count < 100 * FRAME_DIV) begin
			last_x = obstacle_x;
			@(negedge Clock);
			count++;
		end
		if (!crashed)
			fail_check("no crash with the player left on the ground");
		check_range("obstacle x at crash", 42, 78, last_x);
		seen = 1;
		repeat (3 * FRAME_DIV) begin
			@(negedge Clock);
			seen &= crashed;
		end
		check_value("crash latch", 1, seen);
		check_display(1, 1);   // Score frozen, high score taken
		end_test();

		begin_test("restart");
		restart_game();
		@(negedge Clock);
		check_display(0, 1);
		check_value("crashed after restart", 0, crashed);
		check_value("obstacle x after restart", START_X, obstacle_x);
		check_value("player y after restart", GROUND_Y, player.y);
		end_test();

		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
			tests_passed + tests_failed, tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clock,
	output logic o_rst_n
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// Reset released on a rising edge like every other input
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_rst_n <= 1'b1;
	end

endmodule

// ==== design/dino_game_top.sv ====
`timescale 1ns/10ps

module dino_game_top #(
	parameter int CLK_HZ     = 25_000_000,
	parameter int BAUD       = 115_200,
	parameter int FRAME_DIV  = 416_667,   // About 60 frames per second
	parameter int DUCK_TICKS = 30
) (
	input  logic               Clock,
	input  logic               rst_n,
	input  logic               i_uart_rx,
	input  logic               i_key_jump_n,
	input  logic               i_key_duck_n,
	input  logic               i_restart_n,
	output dino_pkg::seg_t     o_hex0,
	output dino_pkg::seg_t     o_hex1,
	output dino_pkg::seg_t     o_hex2,
	output dino_pkg::seg_t     o_hex3,
	output dino_pkg::seg_t     o_hex4,
	output dino_pkg::seg_t     o_hex5,
	output logic               o_crashed,
	output dino_pkg::player_t  o_player,
	output dino_pkg::x_coord_t o_obstacle_x
);

	logic             byte_valid;
	dino_pkg::byte_t  rx_byte;
	dino_pkg::cmd_t   cmd;
	logic             restart;
	logic             frame_tick;
	logic             hold;
	logic             respawn;
	dino_pkg::score_t score;
	dino_pkg::score_t high_score;

	uart_rx #(.CLK_HZ(CLK_HZ), .BAUD(BAUD)) u_uart_rx (
		.Clock(Clock), .rst_n(rst_n), .i_rx(i_uart_rx),
		.o_byte_valid(byte_valid), .o_byte(rx_byte)
	);

	command_input u_command_input (
		.Clock(Clock), .rst_n(rst_n), .i_byte_valid(byte_valid), .i_byte(rx_byte),
		.i_key_jump_n(i_key_jump_n), .i_key_duck_n(i_key_duck_n),
		.i_restart_n(i_restart_n), .o_cmd(cmd), .o_restart(restart)
	);

	player_motion #(.FRAME_DIV(FRAME_DIV), .DUCK_TICKS(DUCK_TICKS)) u_player_motion (
		.Clock(Clock), .rst_n(rst_n), .i_cmd(cmd), .i_hold(hold),
		.o_frame_tick(frame_tick), .o_player(o_player)
	);

	obstacle_motion u_obstacle_motion (
		.Clock(Clock), .rst_n(rst_n), .i_frame_tick(frame_tick),
		.i_respawn(respawn), .i_hold(hold), .o_obstacle_x(o_obstacle_x)
	);

	hit_score u_hit_score (
		.Clock(Clock), .rst_n(rst_n), .i_player(o_player), .i_obstacle_x(o_obstacle_x),
		.i_restart(restart), .o_crashed(o_crashed), .o_hold(hold), .o_respawn(respawn),
		.o_score(score), .o_high_score(high_score)
	);

	score_display u_score_display (
		.i_score(score), .i_high_score(high_score),
		.o_hex0(o_hex0), .o_hex1(o_hex1), .o_hex2(o_hex2),
		.o_hex3(o_hex3), .o_hex4(o_hex4), .o_hex5(o_hex5)
	);

endmodule

// ==== design/score_display.sv ====
`timescale 1ns/10ps

module score_display (
	input  dino_pkg::score_t i_score,
	input  dino_pkg::score_t i_high_score,
	output dino_pkg::seg_t   o_hex0,
	output dino_pkg::seg_t   o_hex1,
	output dino_pkg::seg_t   o_hex2,
	output dino_pkg::seg_t   o_hex3,
	output dino_pkg::seg_t   o_hex4,
	output dino_pkg::seg_t   o_hex5
);

	function automatic dino_pkg::digit_t digit_of(input dino_pkg::score_t value,
		input int unsigned weight);
		return dino_pkg::digit_t'((value / weight) % 10);
	endfunction

	// Active low, segment a in bit 0
	function automatic dino_pkg::seg_t seg_encode(input dino_pkg::digit_t digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;   // Blank
		endcase
	endfunction

	assign o_hex0 = seg_encode(digit_of(i_score, 1));
	assign o_hex1 = seg_encode(digit_of(i_score, 10));
	assign o_hex2 = seg_encode(digit_of(i_score, 100));
	assign o_hex3 = seg_encode(digit_of(i_high_score, 1));
	assign o_hex4 = seg_encode(digit_of(i_high_score, 10));
	assign o_hex5 = seg_encode(digit_of(i_high_score, 100));

endmodule

// ==== design/hit_score.sv ====
`timescale 1ns/10ps

module hit_score (
	input  logic               Clock,
	input  logic               rst_n,
	input  dino_pkg::player_t  i_player,
	input  dino_pkg::x_coord_t i_obstacle_x,
	input  logic               i_restart,
	output logic               o_crashed,
	output logic               o_hold,
	output logic               o_respawn,
	output dino_pkg::score_t   o_score,
	output dino_pkg::score_t   o_high_score
);

	localparam dino_pkg::x_coord_t PLY_LEFT =
		dino_pkg::x_coord_t'(dino_pkg::PLAYER_X + dino_pkg::PLAYER_HIT_OFS);
	localparam dino_pkg::x_coord_t PLY_RIGHT = PLY_LEFT + dino_pkg::x_coord_t'(dino_pkg::PLAYER_HIT_W);
	localparam dino_pkg::y_coord_t OBS_TOP    = dino_pkg::y_coord_t'(dino_pkg::OBS_Y);
	localparam dino_pkg::y_coord_t OBS_BOTTOM =
		dino_pkg::y_coord_t'(dino_pkg::OBS_Y + dino_pkg::OBS_SIZE);
	localparam dino_pkg::x_coord_t PASS_X = dino_pkg::x_coord_t'(dino_pkg::PLAYER_X);

	dino_pkg::y_coord_t top_ofs;
	dino_pkg::y_coord_t height;
	dino_pkg::y_coord_t ply_top;
	dino_pkg::y_coord_t ply_bottom;
	dino_pkg::x_coord_t obs_right;
	logic               overlap;
	logic               overlap_q;
	dino_pkg::x_coord_t prev_x;
	logic               armed;       // Cleared once a pass is counted
	logic               pass;

	// Ducking lowers the head and shortens the box
	assign top_ofs    = dino_pkg::y_coord_t'(i_player.ducking ? dino_pkg::DUCK_TOP : dino_pkg::STAND_TOP);
	assign height     = dino_pkg::y_coord_t'(i_player.ducking ? dino_pkg::DUCK_H : dino_pkg::STAND_H);
	assign ply_top    = i_player.y + top_ofs;
	assign ply_bottom = ply_top + height;
	assign obs_right  = i_obstacle_x + dino_pkg::x_coord_t'(dino_pkg::OBS_SIZE);

	// Closed intervals on both axes
	assign overlap = (PLY_RIGHT >= i_obstacle_x) && (PLY_LEFT <= obs_right) &&
		(ply_bottom >= OBS_TOP) && (ply_top <= OBS_BOTTOM);

	assign pass   = armed && (prev_x > PASS_X) && (i_obstacle_x <= PASS_X);
	assign o_hold = o_crashed | i_restart;

	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			o_crashed <= 1'b0;
			o_score   <= '0;
			o_respawn <= 1'b0;
			overlap_q <= 1'b0;
			armed     <= 1'b1;
			prev_x    <= dino_pkg::x_coord_t'(dino_pkg::SCREEN_W - dino_pkg::OBS_SIZE);
		end else begin
			o_respawn <= 1'b0;
			overlap_q <= overlap;
			prev_x    <= i_obstacle_x;
			if (overlap)
				o_crashed <= 1'b1;
			if (!o_crashed) begin
				if (pass) begin
					armed <= 1'b0;
					if (!overlap && !overlap_q) begin   // Clean pass only
						o_score   <= o_score + 1'b1;
						o_respawn <= 1'b1;
					end
				end else if (i_obstacle_x > prev_x) begin
					armed <= 1'b1;   // Respawned or wrapped
				end
			end
		end
	end

	// Survives restart, only power-on reset clears it
	always_ff @(posedge Clock) begin
		if (!rst_n)
			o_high_score <= '0;
		else if (overlap && !o_crashed && !i_restart && (o_score > o_high_score))
			o_high_score <= o_score;
	end

	a_crash_sticky: assert property (@(posedge Clock) disable iff (!rst_n)
		$fell(o_crashed) |-> $past(i_restart));

endmodule

// ==== design/obstacle_motion.sv ====
`timescale 1ns/10ps

module obstacle_motion (
	input  logic               Clock,
	input  logic               rst_n,
	input  logic               i_frame_tick,
	input  logic               i_respawn,
	input  logic               i_hold,
	output dino_pkg::x_coord_t o_obstacle_x
);

	localparam dino_pkg::x_coord_t START_X =
		dino_pkg::x_coord_t'(dino_pkg::SCREEN_W - dino_pkg::OBS_SIZE);
	localparam dino_pkg::x_coord_t WRAP_X = dino_pkg::x_coord_t'(2 * dino_pkg::OBS_STEP);

	logic [15:0]        lfsr;
	logic               feedback;
	dino_pkg::x_coord_t offset;

	// Taps 16, 15, 13, 4
	assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
	assign offset   = dino_pkg::x_coord_t'(lfsr % dino_pkg::RESPAWN_SPAN);

	// Free running, even during hold, so each round spawns differently
	always_ff @(posedge Clock) begin
		if (!rst_n)
			lfsr <= 16'hACE1;
		else
			lfsr <= {lfsr[14:0], feedback};
	end

	always_ff @(posedge Clock) begin
		if (!rst_n || i_hold)
			o_obstacle_x <= START_X;
		else if (i_respawn)
			o_obstacle_x <= START_X + offset;   // Up to 403, off screen right
		else if (i_frame_tick) begin
			if (o_obstacle_x <= WRAP_X)
				o_obstacle_x <= START_X;
			else
				o_obstacle_x <= o_obstacle_x - dino_pkg::x_coord_t'(dino_pkg::OBS_STEP);
		end
	end

endmodule

// ==== design/player_motion.sv ====
`timescale 1ns/10ps

module player_motion #(
	parameter int FRAME_DIV  = 64,
	parameter int DUCK_TICKS = 30
) (
	input  logic              Clock,
	input  logic              rst_n,
	input  dino_pkg::cmd_t    i_cmd,
	input  logic              i_hold,
	output logic              o_frame_tick,
	output dino_pkg::player_t o_player
);

	localparam int FRAME_W = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;
	localparam int DUCK_W  = $clog2(DUCK_TICKS + 1);

	logic [FRAME_W-1:0]      frame_cnt;
	dino_pkg::player_state_t state;
	logic signed [5:0]       velocity;   // Positive is upward
	dino_pkg::y_coord_t      y_q;
	logic signed [9:0]       y_next;
	logic [DUCK_W-1:0]       duck_cnt;
	logic                    ducking;

	always_ff @(posedge Clock) begin
		if (!rst_n || i_hold) begin
			frame_cnt    <= '0;
			o_frame_tick <= 1'b0;
		end else if (frame_cnt == FRAME_W'(FRAME_DIV - 1)) begin
			frame_cnt    <= '0;
			o_frame_tick <= 1'b1;
		end else begin
			frame_cnt    <= frame_cnt + 1'b1;
			o_frame_tick <= 1'b0;
		end
	end

	// Screen y grows downward
	assign y_next  = $signed({2'b00, y_q}) - velocity;
	assign ducking = (duck_cnt != '0);

	always_ff @(posedge Clock) begin
		if (!rst_n || i_hold) begin
			state    <= dino_pkg::RUNNING;
			y_q      <= dino_pkg::y_coord_t'(dino_pkg::GROUND_Y);
			velocity <= '0;
		end else begin
			case (state)
				dino_pkg::RUNNING: if (i_cmd.jump && !ducking) begin
					state    <= dino_pkg::AIRBORNE;
					velocity <= 6'(dino_pkg::JUMP_VELOCITY);
				end
				dino_pkg::AIRBORNE: if (o_frame_tick) begin
					if (y_next >= dino_pkg::GROUND_Y) begin
						y_q      <= dino_pkg::y_coord_t'(dino_pkg::GROUND_Y);   // Landed
						velocity <= '0;
						state    <= dino_pkg::RUNNING;
					end else begin
						y_q      <= y_next[7:0];
						velocity <= velocity - 6'(dino_pkg::GRAVITY);
					end
				end
				default: state <= dino_pkg::RUNNING;
			endcase
		end
	end

	// Duck only from the ground, counted in frame ticks
	always_ff @(posedge Clock) begin
		if (!rst_n || i_hold)
			duck_cnt <= '0;
		else if (i_cmd.duck && (state == dino_pkg::RUNNING) && !ducking)
			duck_cnt <= DUCK_W'(DUCK_TICKS);
		else if (o_frame_tick && ducking)
			duck_cnt <= duck_cnt - 1'b1;
	end

	assign o_player = '{y: y_q, ducking: ducking};

	a_above_ground: assert property (@(posedge Clock) disable iff (!rst_n)
		o_player.y <= dino_pkg::y_coord_t'(dino_pkg::GROUND_Y));

endmodule

// ==== design/command_input.sv ====
`timescale 1ns/10ps

module command_input (
	input  logic            Clock,
	input  logic            rst_n,
	input  logic            i_byte_valid,
	input  dino_pkg::byte_t i_byte,
	input  logic            i_key_jump_n,
	input  logic            i_key_duck_n,
	input  logic            i_restart_n,
	output dino_pkg::cmd_t  o_cmd,
	output logic            o_restart
);

	logic [2:0] key_meta;   // {restart, duck, jump}, high while pressed
	logic [2:0] key_sync;
	logic [1:0] key_prev;
	logic [1:0] key_rise;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			key_meta <= '0;
			key_sync <= '0;
			key_prev <= '0;
		end else begin
			key_meta <= ~{i_restart_n, i_key_duck_n, i_key_jump_n};
			key_sync <= key_meta;
			key_prev <= key_sync[1:0];
		end
	end

	assign key_rise  = key_sync[1:0] & ~key_prev;
	assign o_restart = key_sync[2];

	// Keys and UART letters merge into one pulse per command
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			o_cmd <= '0;
		end else begin
			o_cmd.jump <= key_rise[0] | (i_byte_valid && (i_byte == dino_pkg::CMD_JUMP));
			o_cmd.duck <= key_rise[1] | (i_byte_valid && (i_byte == dino_pkg::CMD_DUCK));
		end
	end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx #(
	parameter int CLK_HZ = 25_000_000,
	parameter int BAUD   = 115_200
) (
	input  logic            Clock,
	input  logic            rst_n,
	input  logic            i_rx,
	output logic            o_byte_valid,
	output dino_pkg::byte_t o_byte
);

	localparam int DIV   = CLK_HZ / (BAUD * 16);
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0]    div_cnt;
	logic                os_tick;    // 16 ticks per bit
	logic                rx_meta;
	logic                rx_sync;
	dino_pkg::rx_state_t state;
	logic [3:0]          os_cnt;
	logic [2:0]          bit_idx;
	dino_pkg::byte_t     shift;
	logic                sample_bit;
	logic                byte_done;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			div_cnt <= '0;
			os_tick <= 1'b0;
		end else if (div_cnt == CNT_W'(DIV - 1)) begin
			div_cnt <= '0;
			os_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			os_tick <= 1'b0;
		end
	end

	// Line idles high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	assign sample_bit = os_tick && (state == dino_pkg::RX_DATA) && (os_cnt == 4'd0);
	assign byte_done  = os_tick && (state == dino_pkg::RX_STOP) && (os_cnt == 4'd0);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state        <= dino_pkg::RX_IDLE;
			os_cnt       <= 4'd0;
			bit_idx      <= 3'd0;
			o_byte_valid <= 1'b0;
		end else begin
			o_byte_valid <= byte_done;
			if (os_tick) begin
				case (state)
					dino_pkg::RX_IDLE: if (!rx_sync) begin
						state  <= dino_pkg::RX_START;
						os_cnt <= 4'd7;       // Half a bit to the start bit middle
					end
					dino_pkg::RX_START: if (os_cnt == 4'd0) begin
						// Glitch shorter than half a bit goes back to idle
						state   <= rx_sync ? dino_pkg::RX_IDLE : dino_pkg::RX_DATA;
						os_cnt  <= 4'd15;
						bit_idx <= 3'd0;
					end else begin
						os_cnt <= os_cnt - 1'b1;
					end
					dino_pkg::RX_DATA: if (os_cnt == 4'd0) begin
						os_cnt  <= 4'd15;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= dino_pkg::RX_STOP;
					end else begin
						os_cnt <= os_cnt - 1'b1;
					end
					dino_pkg::RX_STOP: if (os_cnt == 4'd0)
						state <= dino_pkg::RX_IDLE;
					else
						os_cnt <= os_cnt - 1'b1;
					default: state <= dino_pkg::RX_IDLE;
				endcase
			end
		end
	end

	// LSB first, so shift in from the top
	always_ff @(posedge Clock) begin
		if (sample_bit)
			shift <= {rx_sync, shift[7:1]};
		if (byte_done)
			o_byte <= shift;
	end

	a_valid_single: assert property (@(posedge Clock) disable iff (!rst_n)
		o_byte_valid |=> !o_byte_valid);

endmodule

// ==== design/dino_pkg.sv ====
package dino_pkg;

	// Widths that carry a meaning
	typedef logic [8:0]  x_coord_t;
	typedef logic [7:0]  y_coord_t;
	typedef logic [15:0] score_t;
	typedef logic [3:0]  digit_t;
	typedef logic [6:0]  seg_t;   // Active low, bit 0 is segment a
	typedef logic [7:0]  byte_t;

	typedef enum logic {
		RUNNING,
		AIRBORNE
	} player_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// One-cycle command pulses
	typedef struct packed {
		logic jump;
		logic duck;
	} cmd_t;

	typedef struct packed {
		y_coord_t y;       // Top of the player box
		logic     ducking;
	} player_t;

	// Playfield geometry, 320x240 screen
	localparam int SCREEN_W       = 320;
	localparam int GROUND_Y       = 109;
	localparam int PLAYER_X       = 52;
	localparam int PLAYER_HIT_OFS = 6;
	localparam int PLAYER_HIT_W   = 20;
	localparam int STAND_TOP      = 2;
	localparam int STAND_H        = 28;
	localparam int DUCK_TOP       = 16;   // Head drops when ducking
	localparam int DUCK_H         = 16;
	localparam int OBS_Y          = 105;
	localparam int OBS_SIZE       = 16;
	localparam int OBS_STEP       = 4;
	localparam int RESPAWN_SPAN   = 100;

	// Jump physics in pixels per frame tick
	localparam int JUMP_VELOCITY  = 10;
	localparam int GRAVITY        = 1;

	localparam byte_t CMD_JUMP = "J";
	localparam byte_t CMD_DUCK = "D";

endpackage
